/* pss_detector.f */
source/pss_pkg.sv
source/pss_sample_gate.sv
source/pss_correlator.sv
source/pss_peak_detector.sv
source/pss_id_decider.sv
source/pss_detector.sv
test/pss_detector_tb.sv

/* Bender.yml */
package:
  name: pss_detector

sources:
  - files:
      - source/pss_pkg.sv
      - source/pss_sample_gate.sv
      - source/pss_correlator.sv
      - source/pss_peak_detector.sv
      - source/pss_id_decider.sv
      - source/pss_detector.sv
  - target: test
    files:
      - test/pss_detector_tb.sv

/* test/pss_detector_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module pss_detector_tb;

    localparam int unsigned WINDOW_LEN = 8;
    localparam int unsigned MIN_POWER = 4096;
    localparam int LEN = pss_pkg::PSS_LEN;

    // strobes per frame of noise, sequence and zero tail
    localparam int FRAME_LEN = 76;
    localparam int FRAME_IDLE = 8;
    localparam int MAX_GAP = 3;
    localparam int STIM_CYCLES = 10 * (FRAME_LEN + FRAME_IDLE + 2)
                               + 3 * (FRAME_LEN * (MAX_GAP + 1) + FRAME_IDLE + 2) + 40;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    typedef struct packed {
        logic [31:0] due;
        logic [1:0]  id;
    } pulse_t;

    logic             clk_i;
    logic             reset_ni;
    pss_pkg::sample_t sample_i;
    logic             sample_valid_i;
    pss_pkg::mode_e   mode_i;
    logic [1:0]       requested_id_i;
    logic [1:0]       id_o;
    logic             id_valid_o;

    int          cycle_cnt = 0;
    int          error_cnt = 0;
    pulse_t      due_q [$];
    logic        exp_valid = 1'b0;
    logic [1:0]  exp_id = 2'd0;

    // model state
    pss_pkg::sample_t hist [LEN];
    longint           ring [3][WINDOW_LEN];
    longint           win_sum [3];
    int               wr_ptr;

    pss_detector #(
        .WINDOW_LEN (WINDOW_LEN),
        .MIN_POWER  (MIN_POWER)
    ) i_pss_detector (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .mode_i         (mode_i),
        .requested_id_i (requested_id_i),
        .id_o           (id_o),
        .id_valid_o     (id_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // expected outputs change on the same edge as the DUT's
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!reset_ni) begin
            exp_valid <= 1'b0;
            exp_id    <= 2'd0;
            due_q.delete();
        end else if (due_q.size() > 0 && due_q[0].due == cycle_cnt + 1) begin
            exp_valid <= 1'b1;
            exp_id    <= due_q[0].id;
            void'(due_q.pop_front());
        end else begin
            exp_valid <= 1'b0;
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    assert property (@(posedge clk_i) disable iff (!reset_ni) id_valid_o == exp_valid)
        else begin
            error_cnt++;
            $display("** Error: id_valid_o = %h, expected %h",
                     $sampled(id_valid_o), $sampled(exp_valid));
        end

    assert property (@(posedge clk_i) disable iff (!reset_ni) id_o == exp_id)
        else begin
            error_cnt++;
            $display("** Error: id_o = %h, expected %h", $sampled(id_o), $sampled(exp_id));
        end

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
        end
        $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("run stopped: %0d errors", error_cnt);
        $display("TESTS FAILED");
        $finish;
    end

    // ------------------------------
    // reference model
    // ------------------------------
    task automatic clear_model();
        for (int k = 0; k < LEN; k++) begin
            hist[k] = '0;
        end
        for (int i = 0; i < 3; i++) begin
            win_sum[i] = 0;
            for (int w = 0; w < WINDOW_LEN; w++) begin
                ring[i][w] = 0;
            end
        end
        wr_ptr = 0;
    endtask

    task automatic model_strobe(input pss_pkg::sample_t s);
        longint     acc_re;
        longint     acc_im;
        longint     power;
        longint     tr;
        longint     ti;
        logic [2:0] peaks;
        logic       accept;
        logic [1:0] pick;
        if (mode_i != pss_pkg::MODE_SEARCH && mode_i != pss_pkg::MODE_FIND) begin
            return;
        end
        for (int k = 0; k < LEN - 1; k++) begin
            hist[k] = hist[k + 1];
        end
        hist[LEN - 1] = s;
        for (int i = 0; i < 3; i++) begin
            acc_re = 0;
            acc_im = 0;
            // conj(tap) * sample with tap 0 on the oldest entry
            for (int k = 0; k < LEN; k++) begin
                tr = pss_pkg::PSS_TAPS_RE[i][k] ? -1 : 1;
                ti = pss_pkg::PSS_TAPS_IM[i][k] ? -1 : 1;
                acc_re += tr * hist[k].re + ti * hist[k].im;
                acc_im += tr * hist[k].im - ti * hist[k].re;
            end
            power = acc_re * acc_re + acc_im * acc_im;
            peaks[i] = (power >= MIN_POWER)
                    && (power * WINDOW_LEN > win_sum[i] * pss_pkg::PEAK_FACTOR);
            win_sum[i] = win_sum[i] + power - ring[i][wr_ptr];
            ring[i][wr_ptr] = power;
        end
        wr_ptr = (wr_ptr + 1) % WINDOW_LEN;

        accept = 1'b0;
        pick = 2'd0;
        if (mode_i == pss_pkg::MODE_SEARCH) begin
            for (int i = 0; i < 3; i++) begin
                if (peaks == (3'b001 << i)) begin
                    accept = 1'b1;
                    pick = i[1:0];
                end
            end
        end else if (requested_id_i != 2'd3 && peaks == (3'b001 << requested_id_i)) begin
            accept = 1'b1;
            pick = requested_id_i;
        end
        if (accept) begin
            due_q.push_back('{due: cycle_cnt + 5, id: pick});
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic step(input logic valid, input pss_pkg::sample_t s);
        @(posedge clk_i);
        #1;
        sample_valid_i = valid;
        sample_i = s;
        if (valid) begin
            model_strobe(s);
        end
    endtask

    task automatic set_mode(input pss_pkg::mode_e m, input logic [1:0] req);
        @(posedge clk_i);
        #1;
        sample_valid_i = 1'b0;
        mode_i = m;
        requested_id_i = req;
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        #1;
        reset_ni = 1'b0;
        sample_valid_i = 1'b0;
        clear_model();
        repeat (3) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
    endtask

    task automatic send_frame(input int id, input logic with_seq, input int max_gap);
        pss_pkg::sample_t s;
        int               v;
        for (int n = 0; n < FRAME_LEN; n++) begin
            if (n < 40 || (!with_seq && n < 56)) begin
                v = int'($urandom_range(6)) - 3;
                s.re = v[pss_pkg::SAMPLE_DW-1:0];
                v = int'($urandom_range(6)) - 3;
                s.im = v[pss_pkg::SAMPLE_DW-1:0];
            end else if (n < 56) begin
                s.re = pss_pkg::PSS_TAPS_RE[id][n - 40] ? -8'sd40 : 8'sd40;
                s.im = pss_pkg::PSS_TAPS_IM[id][n - 40] ? -8'sd40 : 8'sd40;
            end else begin
                s = '0;
            end
            repeat ($urandom_range(max_gap)) step(1'b0, '0);
            step(1'b1, s);
        end
        repeat (FRAME_IDLE) step(1'b0, '0);
    endtask

    initial begin
        void'($urandom(53));
        reset_ni = 1'b0;
        sample_i = '0;
        sample_valid_i = 1'b0;
        mode_i = pss_pkg::MODE_SEARCH;
        requested_id_i = 2'd0;
        clear_model();
        repeat (3) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;

        // search for each sequence
        for (int id = 0; id < 3; id++) begin
            send_frame(id, 1'b1, 0);
        end
        send_frame(0, 1'b0, 0);

        // find with matching, other and reserved id
        set_mode(pss_pkg::MODE_FIND, 2'd1);
        send_frame(1, 1'b1, 0);
        set_mode(pss_pkg::MODE_FIND, 2'd2);
        send_frame(0, 1'b1, 0);
        set_mode(pss_pkg::MODE_FIND, 2'd3);
        send_frame(2, 1'b1, 0);

        set_mode(pss_pkg::MODE_PAUSE, 2'd0);
        send_frame(1, 1'b1, 0);
        set_mode(pss_pkg::MODE_SEARCH, 2'd0);
        send_frame(1, 1'b1, 0);

        // random gaps between strobes
        for (int id = 0; id < 3; id++) begin
            send_frame(id, 1'b1, MAX_GAP);
        end

        apply_reset();
        repeat (5) step(1'b0, '0);
        send_frame(2, 1'b1, 0);
        repeat (10) step(1'b0, '0);

        $display("run complete: %0d errors", error_cnt);
        if (error_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/pss_detector.sv */
`timescale 1ns/10ps
`default_nettype none

module pss_detector #(
    parameter int unsigned WINDOW_LEN = 8,
    parameter int unsigned MIN_POWER  = 4096
) (
    input  wire                    clk_i,
    input  wire                    reset_ni,
    input  wire pss_pkg::sample_t  sample_i,
    input  wire                    sample_valid_i,
    input  wire pss_pkg::mode_e    mode_i,
    input  wire [1:0]              requested_id_i,
    output logic [1:0]             id_o,
    output logic                   id_valid_o
);

    pss_pkg::gated_t gated;
    pss_pkg::mode_e  mode_q;
    pss_pkg::corr_t  corr [3];
    logic [2:0]      peak;

    // ------------------------------
    // input side
    // ------------------------------
    pss_sample_gate i_pss_sample_gate (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .mode_i         (mode_i),
        .gated_o        (gated),
        .mode_o         (mode_q)
    );

    // ------------------------------
    // one correlator and peak detector per N_id_2
    // ------------------------------
    for (genvar i = 0; i < 3; i++) begin : gen_id
        pss_correlator #(
            .N_ID (i)
        ) i_pss_correlator (
            .clk_i    (clk_i),
            .reset_ni (reset_ni),
            .gated_i  (gated),
            .corr_o   (corr[i])
        );

        pss_peak_detector #(
            .WINDOW_LEN (WINDOW_LEN),
            .MIN_POWER  (MIN_POWER)
        ) i_pss_peak_detector (
            .clk_i    (clk_i),
            .reset_ni (reset_ni),
            .corr_i   (corr[i]),
            .peak_o   (peak[i])
        );
    end

    // ------------------------------
    // output side
    // ------------------------------
    pss_id_decider i_pss_id_decider (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .peak_i         (peak),
        .mode_i         (mode_q),
        .requested_id_i (requested_id_i),
        .id_o           (id_o),
        .id_valid_o     (id_valid_o)
    );

endmodule

`default_nettype wire

/* source/pss_id_decider.sv */
`timescale 1ns/10ps
`default_nettype none

module pss_id_decider (
    input  wire                  clk_i,
    input  wire                  reset_ni,
    input  wire [2:0]            peak_i,
    input  wire pss_pkg::mode_e  mode_i,
    input  wire [1:0]            requested_id_i,
    output logic [1:0]           id_o,
    output logic                 id_valid_o
);

    logic       one_hot;
    logic [1:0] peak_idx;
    logic       accept;

    always_comb begin
        one_hot  = (peak_i == 3'b001) || (peak_i == 3'b010) || (peak_i == 3'b100);
        peak_idx = peak_i[2] ? 2'd2 : (peak_i[1] ? 2'd1 : 2'd0);

        case (mode_i)
            pss_pkg::MODE_SEARCH: begin
                accept = one_hot;
            end
            pss_pkg::MODE_FIND: begin
                // only the requested bit may be set
                // id 3 never matches
                accept = (requested_id_i != 2'd3)
                      && (peak_i == (3'b001 << requested_id_i));
            end
            default: begin
                accept = 1'b0;
            end
        endcase
    end

    // ------------------------------
    // output register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            id_o       <= 2'd0;
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= accept;
            if (accept) begin
                id_o <= peak_idx;
            end
        end
    end

    // reported id names the single peak that was accepted
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        id_valid_o |-> (id_o < 2'd3) && ($past(peak_i) == (3'b001 << id_o)));

endmodule

`default_nettype wire

/* source/pss_peak_detector.sv */
`timescale 1ns/10ps
`default_nettype none

module pss_peak_detector #(
    parameter int unsigned WINDOW_LEN = 8,
    parameter int unsigned MIN_POWER  = 4096
) (
    input  wire                  clk_i,
    input  wire                  reset_ni,
    input  wire pss_pkg::corr_t  corr_i,
    output logic                 peak_o
);

    localparam int PTR_DW = $clog2(WINDOW_LEN);
    localparam int SUM_DW = pss_pkg::POWER_DW + PTR_DW;
    // room for both power * WINDOW_LEN and sum * PEAK_FACTOR
    localparam int CMP_DW = SUM_DW + $clog2(pss_pkg::PEAK_FACTOR) + 1;

    logic [pss_pkg::POWER_DW-1:0] ring [WINDOW_LEN];
    logic [PTR_DW-1:0]            wr_ptr;
    logic [SUM_DW-1:0]            window_sum;
    logic [CMP_DW-1:0]            scaled_power;
    logic [CMP_DW-1:0]            scaled_sum;
    logic                         is_peak;

    // ------------------------------
    // peak rule
    // ------------------------------
    // compares against the sum of the powers before this one
    assign scaled_power = corr_i.power * WINDOW_LEN;
    assign scaled_sum   = window_sum * pss_pkg::PEAK_FACTOR;

    assign is_peak = corr_i.valid
                  && (corr_i.power >= MIN_POWER)
                  && (scaled_power > scaled_sum);

    // ------------------------------
    // window of past powers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < WINDOW_LEN; k++) begin
                ring[k] <= '0;
            end
            wr_ptr     <= '0;
            window_sum <= '0;
            peak_o     <= 1'b0;
        end else begin
            peak_o <= is_peak;
            if (corr_i.valid) begin
                // oldest entry leaves, newest enters
                window_sum   <= window_sum + corr_i.power - ring[wr_ptr];
                ring[wr_ptr] <= corr_i.power;
                wr_ptr       <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/pss_correlator.sv */
`timescale 1ns/10ps
`default_nettype none

module pss_correlator #(
    parameter int unsigned N_ID = 0
) (
    input  wire                   clk_i,
    input  wire                   reset_ni,
    input  wire pss_pkg::gated_t  gated_i,
    output pss_pkg::corr_t        corr_o
);

    localparam int LEN = pss_pkg::PSS_LEN;
    localparam int CORR_DW = pss_pkg::CORR_DW;
    localparam logic [LEN-1:0] TAP_RE = pss_pkg::PSS_TAPS_RE[N_ID];
    localparam logic [LEN-1:0] TAP_IM = pss_pkg::PSS_TAPS_IM[N_ID];

    pss_pkg::sample_t             history [LEN];
    pss_pkg::sample_t             shifted [LEN];
    logic signed [CORR_DW-1:0]    next_re;
    logic signed [CORR_DW-1:0]    next_im;
    logic signed [CORR_DW-1:0]    sum_re;
    logic signed [CORR_DW-1:0]    sum_im;
    logic                         sum_valid;
    logic [pss_pkg::POWER_DW-1:0] sq_re;
    logic [pss_pkg::POWER_DW-1:0] sq_im;
    logic [pss_pkg::POWER_DW-1:0] power_q;
    logic                         valid_q;

    // ------------------------------
    // stage 1: shift and correlate
    // ------------------------------
    // history as it looks once the new sample is in, oldest at index 0
    always_comb begin
        for (int k = 0; k < LEN - 1; k++) begin
            shifted[k] = history[k + 1];
        end
        shifted[LEN - 1] = gated_i.sample;
    end

    // conj(a + jb) * (x + jy) = (ax + by) + j(ay - bx), with a, b = +-1
    always_comb begin
        next_re = '0;
        next_im = '0;
        for (int k = 0; k < LEN; k++) begin
            if (TAP_RE[k]) begin
                next_re = next_re - shifted[k].re;
                next_im = next_im - shifted[k].im;
            end else begin
                next_re = next_re + shifted[k].re;
                next_im = next_im + shifted[k].im;
            end
            if (TAP_IM[k]) begin
                next_re = next_re - shifted[k].im;
                next_im = next_im + shifted[k].re;
            end else begin
                next_re = next_re + shifted[k].im;
                next_im = next_im - shifted[k].re;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < LEN; k++) begin
                history[k] <= '0;
            end
            sum_valid <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            sum_valid <= gated_i.valid;
            valid_q   <= sum_valid;
            if (gated_i.valid) begin
                history <= shifted;
            end
        end
    end

    // ------------------------------
    // stage 2: power
    // ------------------------------
    assign sq_re = sum_re * sum_re;
    assign sq_im = sum_im * sum_im;

    always_ff @(posedge clk_i) begin
        if (gated_i.valid) begin
            sum_re <= next_re;
            sum_im <= next_im;
        end
        if (sum_valid) begin
            power_q <= sq_re + sq_im;
        end
    end

    assign corr_o.valid = valid_q;
    assign corr_o.power = power_q;

    // two cycles behind the gated strobe, three behind the sample strobe
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        corr_o.valid == $past(gated_i.valid, 2));

endmodule

`default_nettype wire

/* source/pss_sample_gate.sv */
`timescale 1ns/10ps
`default_nettype none

module pss_sample_gate (
    input  wire                      clk_i,
    input  wire                      reset_ni,
    input  wire pss_pkg::sample_t    sample_i,
    input  wire                      sample_valid_i,
    input  wire pss_pkg::mode_e      mode_i,
    output pss_pkg::gated_t          gated_o,
    output pss_pkg::mode_e           mode_o
);

    logic             run;
    logic             valid_q;
    pss_pkg::sample_t sample_q;

    // only search and find feed the correlators
    assign run = (mode_i == pss_pkg::MODE_SEARCH) || (mode_i == pss_pkg::MODE_FIND);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            mode_o  <= pss_pkg::MODE_SEARCH;
            valid_q <= 1'b0;
        end else begin
            mode_o  <= mode_i;
            valid_q <= sample_valid_i && run;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            sample_q <= sample_i;
        end
    end

    assign gated_o.valid  = valid_q;
    assign gated_o.sample = sample_q;

    // paused samples never reach the correlator history
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        gated_o.valid |-> (mode_o == pss_pkg::MODE_SEARCH) || (mode_o == pss_pkg::MODE_FIND));

endmodule

`default_nettype wire

/* source/pss_pkg.sv */
`default_nettype none

package pss_pkg;

    // ------------------------------
    // fixed widths
    // ------------------------------
    localparam int SAMPLE_DW = 8;
    localparam int PSS_LEN = 16;
    localparam int POWER_DW = 32;

    // 16 terms of up to 2 * 2^(SAMPLE_DW-1) each, plus sign
    localparam int CORR_DW = SAMPLE_DW + 2 + $clog2(PSS_LEN);

    // power must beat the window average by this ratio
    localparam int unsigned PEAK_FACTOR = 4;

    // ------------------------------
    // types
    // ------------------------------
    typedef struct packed {
        logic signed [SAMPLE_DW-1:0] re;
        logic signed [SAMPLE_DW-1:0] im;
    } sample_t;

    typedef struct packed {
        logic    valid;
        sample_t sample;
    } gated_t;

    typedef struct packed {
        logic                valid;
        logic [POWER_DW-1:0] power;
    } corr_t;

    // 2'd3 is reserved and behaves like pause
    typedef enum logic [1:0] {
        MODE_SEARCH = 2'd0,
        MODE_FIND   = 2'd1,
        MODE_PAUSE  = 2'd2
    } mode_e;

    // ------------------------------
    // tap signs, one word per N_id_2
    // ------------------------------
    // bit k set means tap k is -1, tap 0 meets the oldest sample
    localparam logic [PSS_LEN-1:0] PSS_TAPS_RE [3] = '{16'hB4E1, 16'h3A96, 16'hD12B};
    localparam logic [PSS_LEN-1:0] PSS_TAPS_IM [3] = '{16'h6C35, 16'hA5C7, 16'h1E9D};

endpackage

`default_nettype wire
